/* source/csrPkg.sv */
`default_nettype none

package csrPkg;

    localparam int xlen = 32;
    localparam int addrWidth = 12;
    localparam int counterWidth = 64;
    localparam int commitWidth = 3; // retired per cycle, 0..4

    localparam logic [addrWidth-1:0] addrMstatus = 12'h300;
    localparam logic [addrWidth-1:0] addrMisa = 12'h301;
    localparam logic [addrWidth-1:0] addrMie = 12'h304;
    localparam logic [addrWidth-1:0] addrMtvec = 12'h305;
    localparam logic [addrWidth-1:0] addrMcounteren = 12'h306;
    localparam logic [addrWidth-1:0] addrMcountinhibit = 12'h320;
    localparam logic [addrWidth-1:0] addrMscratch = 12'h340;
    localparam logic [addrWidth-1:0] addrMepc = 12'h341;
    localparam logic [addrWidth-1:0] addrMcause = 12'h342;
    localparam logic [addrWidth-1:0] addrMip = 12'h344;
    localparam logic [addrWidth-1:0] addrMcycle = 12'hB00;
    localparam logic [addrWidth-1:0] addrMcycleh = 12'hB80;
    localparam logic [addrWidth-1:0] addrMinstret = 12'hB02;
    localparam logic [addrWidth-1:0] addrMinstreth = 12'hB82;
    localparam logic [addrWidth-1:0] addrCycle = 12'hC00;
    localparam logic [addrWidth-1:0] addrCycleh = 12'hC80;
    localparam logic [addrWidth-1:0] addrInstret = 12'hC02;
    localparam logic [addrWidth-1:0] addrInstreth = 12'hC82;
    localparam logic [addrWidth-1:0] addrMhartid = 12'hF14;

    localparam logic [xlen-1:0] misaValue = 32'h4010_0100; // rv32, I and U

    // bit positions in mip / mie
    localparam int irqSoft = 3;
    localparam int irqTimer = 7;
    localparam int irqExt = 11;

    typedef enum logic [1:0] {
        privUser = 2'd0,
        privMachine = 2'd3
    } PrivLevel;

    typedef enum logic [2:0] {
        opRead,
        opWrite,
        opSet,
        opClear,
        opMret
    } CsrOp;

    typedef enum logic [1:0] {
        flagNone,
        flagIllegal,
        flagXret
    } RespFlag;

    typedef struct packed {
        logic valid;
        CsrOp op;
        logic [addrWidth-1:0] addr;
        logic [xlen-1:0] operand;
    } CsrReq;

    typedef struct packed {
        logic valid;
        RespFlag flag;
        logic [xlen-1:0] result;
    } CsrResp;

    typedef struct packed {
        logic en;
        logic [addrWidth-1:0] addr;
        logic [xlen-1:0] data;
    } CsrWrite;

    typedef struct packed {
        logic valid;
        logic isInterrupt;
        logic [3:0] cause;
        logic [xlen-1:0] pc;
    } TrapInfo;

    typedef struct packed {
        logic mie;
        logic mpie;
        PrivLevel mpp;
    } MstatusBits;

    typedef struct packed {
        PrivLevel priv;
        logic [xlen-3:0] mtvecBase;
        logic [xlen-2:0] retvec;
        logic interruptPending;
        logic [3:0] interruptCause;
    } TrapCtrl;

endpackage

`default_nettype wire

/* source/csrCounters.sv */
`timescale 1ns/1ns
`default_nettype none

module csrCounters (
    input wire clk,
    input wire rst,
    input wire csrPkg::PrivLevel priv,
    input wire [csrPkg::commitWidth-1:0] commitCount,
    input wire csrPkg::CsrWrite wr,
    input wire [csrPkg::addrWidth-1:0] addr,
    output logic [csrPkg::xlen-1:0] rdata,
    output logic hit,
    output logic userDenied
);
    import csrPkg::*;

    logic [counterWidth-1:0] mcycle;
    logic [counterWidth-1:0] minstret;
    logic inhibitCy, inhibitIr; // mcountinhibit bits 0 and 2
    logic enableCy, enableIr;   // mcounteren bits 0 and 2

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
            minstret <= '0;
            inhibitCy <= 1'b0;
            inhibitIr <= 1'b0;
            enableCy <= 1'b0;
            enableIr <= 1'b0;
        end else begin
            if (!inhibitCy)
                mcycle <= mcycle + counterWidth'(1);
            if (!inhibitIr)
                minstret <= minstret + counterWidth'(commitCount);

            // a write replaces this cycle's increment
            if (wr.en) begin
                case (wr.addr)
                    addrMcycle: mcycle <= {mcycle[63:32], wr.data};
                    addrMcycleh: mcycle <= {wr.data, mcycle[31:0]};
                    addrMinstret: minstret <= {minstret[63:32], wr.data};
                    addrMinstreth: minstret <= {wr.data, minstret[31:0]};
                    addrMcountinhibit: {inhibitIr, inhibitCy} <= {wr.data[2], wr.data[0]};
                    addrMcounteren: {enableIr, enableCy} <= {wr.data[2], wr.data[0]};
                    default: ;
                endcase
            end
        end
    end

    // addr[7] picks the high half
    always_comb begin
        rdata = '0;
        hit = 1'b1;
        userDenied = 1'b0;
        case (addr)
            addrMcycle, addrMcycleh: rdata = addr[7] ? mcycle[63:32] : mcycle[31:0];
            addrMinstret, addrMinstreth: rdata = addr[7] ? minstret[63:32] : minstret[31:0];
            addrCycle, addrCycleh: begin
                rdata = addr[7] ? mcycle[63:32] : mcycle[31:0];
                userDenied = (priv == privUser) && !enableCy;
            end
            addrInstret, addrInstreth: begin
                rdata = addr[7] ? minstret[63:32] : minstret[31:0];
                userDenied = (priv == privUser) && !enableIr;
            end
            addrMcountinhibit: rdata = {29'b0, inhibitIr, 1'b0, inhibitCy};
            addrMcounteren: rdata = {29'b0, enableIr, 1'b0, enableCy};
            default: hit = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* source/csrTrapState.sv */
`timescale 1ns/1ns
`default_nettype none

module csrTrapState (
    input wire clk,
    input wire rst,
    input wire csrPkg::CsrWrite wr,
    input wire [csrPkg::addrWidth-1:0] addr,
    input wire csrPkg::TrapInfo trap,
    input wire mret,
    output logic [csrPkg::xlen-1:0] rdata,
    output logic hit,
    output csrPkg::PrivLevel priv,
    output csrPkg::MstatusBits status,
    output logic [csrPkg::xlen-3:0] mtvecBase,
    output logic [csrPkg::xlen-2:0] retvec
);
    import csrPkg::*;

    logic [xlen-1:0] mscratch;
    logic [xlen-1:1] mepc; // bit 0 reads as zero
    logic mcauseInt;
    logic [3:0] mcauseCode;

    always_ff @(posedge clk) begin
        if (rst) begin
            priv <= privMachine;
            status <= '0;
            mtvecBase <= '0;
            mscratch <= '0;
            mepc <= '0;
            mcauseInt <= 1'b0;
            mcauseCode <= '0;
            retvec <= '0;
        end else if (trap.valid) begin
            mepc <= trap.pc[xlen-1:1];
            mcauseInt <= trap.isInterrupt;
            mcauseCode <= trap.cause;
            status.mpie <= status.mie;
            status.mie <= 1'b0;
            status.mpp <= priv;
            priv <= privMachine;
        end else if (mret) begin
            status.mie <= status.mpie;
            status.mpp <= privUser;
            priv <= status.mpp;
            retvec <= mepc;
        end else if (wr.en) begin
            case (wr.addr)
                addrMstatus: begin
                    status.mie <= wr.data[3];
                    status.mpie <= wr.data[7];
                    // only M and U are legal in mpp
                    if (wr.data[12:11] == 2'b11)
                        status.mpp <= privMachine;
                    else
                        status.mpp <= privUser;
                end
                addrMtvec: mtvecBase <= wr.data[xlen-1:2]; // direct mode only
                addrMscratch: mscratch <= wr.data;
                addrMepc: mepc <= wr.data[xlen-1:1];
                addrMcause: begin
                    mcauseInt <= wr.data[31];
                    mcauseCode <= wr.data[3:0];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        rdata = '0;
        hit = 1'b1;
        case (addr)
            addrMstatus: begin
                rdata[3] = status.mie;
                rdata[7] = status.mpie;
                rdata[12:11] = status.mpp;
            end
            addrMisa: rdata = misaValue;
            addrMtvec: rdata = {mtvecBase, 2'b00};
            addrMscratch: rdata = mscratch;
            addrMepc: rdata = {mepc, 1'b0};
            addrMcause: rdata = {mcauseInt, 27'b0, mcauseCode};
            addrMhartid: rdata = '0; // single hart
            default: hit = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* source/csrInterrupt.sv */
`timescale 1ns/1ns
`default_nettype none

module csrInterrupt (
    input wire clk,
    input wire rst,
    input wire csrPkg::CsrWrite wr,
    input wire [csrPkg::addrWidth-1:0] addr,
    input wire csrPkg::PrivLevel priv,
    input wire csrPkg::MstatusBits status,
    input wire [csrPkg::counterWidth-1:0] mtime,
    input wire [csrPkg::counterWidth-1:0] mtimecmp,
    input wire softIrq,
    input wire extIrq,
    output logic [csrPkg::xlen-1:0] rdata,
    output logic hit,
    output logic pending,
    output logic [3:0] cause
);
    import csrPkg::*;

    logic [xlen-1:0] mie;
    logic [xlen-1:0] mip;
    logic [xlen-1:0] active;
    logic timerPending;
    logic enabled;

    always_ff @(posedge clk) begin
        if (rst) begin
            mie <= '0;
            timerPending <= 1'b0;
        end else begin
            timerPending <= mtime >= mtimecmp;
            if (wr.en && wr.addr == addrMie) begin
                mie[irqSoft] <= wr.data[irqSoft];
                mie[irqTimer] <= wr.data[irqTimer];
                mie[irqExt] <= wr.data[irqExt];
            end
        end
    end

    always_comb begin
        mip = '0;
        mip[irqSoft] = softIrq;
        mip[irqTimer] = timerPending;
        mip[irqExt] = extIrq;
    end

    assign active = mip & mie;
    assign enabled = (priv == privUser) || status.mie; // user mode always takes M interrupts
    assign pending = enabled && (|active);

    // external, then soft, then timer
    always_comb begin
        cause = '0;
        if (pending) begin
            if (active[irqExt])
                cause = 4'(irqExt);
            else if (active[irqSoft])
                cause = 4'(irqSoft);
            else
                cause = 4'(irqTimer);
        end
    end

    always_comb begin
        rdata = '0;
        hit = 1'b1;
        case (addr)
            addrMie: rdata = mie;
            addrMip: rdata = mip; // writes are ignored
            default: hit = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* source/csrAccess.sv */
`timescale 1ns/1ns
`default_nettype none

module csrAccess (
    input wire clk,
    input wire rst,
    input wire csrPkg::CsrReq req,
    input wire csrPkg::PrivLevel priv,
    input wire [csrPkg::xlen-1:0] cntRdata,
    input wire cntHit,
    input wire [csrPkg::xlen-1:0] trapRdata,
    input wire trapHit,
    input wire [csrPkg::xlen-1:0] irqRdata,
    input wire irqHit,
    input wire userDenied,
    output csrPkg::CsrWrite wr,
    output logic mret,
    output csrPkg::CsrResp resp
);
    import csrPkg::*;

    logic [xlen-1:0] oldValue;
    logic [xlen-1:0] wdata;
    logic anyHit;
    logic isMret;
    logic isWrite;
    logic illegal;

    // each block drives zero on a miss
    assign oldValue = cntRdata | trapRdata | irqRdata;
    assign anyHit = cntHit | trapHit | irqHit;
    assign isMret = req.op == opMret;
    assign isWrite = req.op inside {opWrite, opSet, opClear};

    always_comb begin
        if (isMret) begin
            illegal = priv == privUser; // addr is don't care for mret
        end else begin
            illegal = !anyHit || userDenied;
            if (req.addr[9:8] > priv)
                illegal = 1'b1;
            if (isWrite && req.addr[11:10] == 2'b11)
                illegal = 1'b1; // read-only space
        end
    end

    always_comb begin
        case (req.op)
            opWrite: wdata = req.operand;
            opSet: wdata = oldValue | req.operand;
            opClear: wdata = oldValue & ~req.operand;
            default: wdata = oldValue;
        endcase
    end

    assign wr.en = req.valid && isWrite && !illegal;
    assign wr.addr = req.addr;
    assign wr.data = wdata;
    assign mret = req.valid && isMret && !illegal;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp.valid <= 1'b0;
        end else begin
            resp.valid <= req.valid;
        end

        if (req.valid) begin
            if (illegal) begin
                resp.flag <= flagIllegal;
                resp.result <= '0;
            end else if (isMret) begin
                resp.flag <= flagXret;
                resp.result <= '0;
            end else begin
                resp.flag <= flagNone;
                resp.result <= oldValue; // value before the write
            end
        end
    end

endmodule

`default_nettype wire

/* source/csrUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module csrUnit (
    input wire clk,
    input wire rst,
    input wire csrPkg::CsrReq req,
    input wire csrPkg::TrapInfo trap,
    input wire [csrPkg::commitWidth-1:0] commitCount,
    input wire [csrPkg::counterWidth-1:0] mtime,
    input wire [csrPkg::counterWidth-1:0] mtimecmp,
    input wire softIrq,
    input wire extIrq,
    output csrPkg::CsrResp resp,
    output wire csrPkg::TrapCtrl trapCtrl
);
    import csrPkg::*;

    CsrWrite wr;
    PrivLevel priv;
    MstatusBits status;
    logic mret;
    logic [xlen-1:0] cntRdata, trapRdata, irqRdata;
    logic cntHit, trapHit, irqHit;
    logic userDenied;
    logic [xlen-3:0] mtvecBase;
    logic [xlen-2:0] retvec;
    logic irqPending;
    logic [3:0] irqCause;

    csrAccess access (
        .clk(clk), .rst(rst), .req(req), .priv(priv),
        .cntRdata(cntRdata), .cntHit(cntHit),
        .trapRdata(trapRdata), .trapHit(trapHit),
        .irqRdata(irqRdata), .irqHit(irqHit),
        .userDenied(userDenied), .wr(wr), .mret(mret), .resp(resp)
    );

    csrCounters counters (
        .clk(clk), .rst(rst), .priv(priv), .commitCount(commitCount),
        .wr(wr), .addr(req.addr),
        .rdata(cntRdata), .hit(cntHit), .userDenied(userDenied)
    );

    csrTrapState trapState (
        .clk(clk), .rst(rst), .wr(wr), .addr(req.addr), .trap(trap), .mret(mret),
        .rdata(trapRdata), .hit(trapHit), .priv(priv), .status(status),
        .mtvecBase(mtvecBase), .retvec(retvec)
    );

    csrInterrupt interrupts (
        .clk(clk), .rst(rst), .wr(wr), .addr(req.addr), .priv(priv), .status(status),
        .mtime(mtime), .mtimecmp(mtimecmp), .softIrq(softIrq), .extIrq(extIrq),
        .rdata(irqRdata), .hit(irqHit), .pending(irqPending), .cause(irqCause)
    );

    assign trapCtrl = '{
        priv: priv,
        mtvecBase: mtvecBase,
        retvec: retvec,
        interruptPending: irqPending,
        interruptCause: irqCause
    };

endmodule

`default_nettype wire

/* tests/csrUnitTb.sv */
`timescale 1ns/1ns
`default_nettype none

module csrUnitTb;
    import csrPkg::*;

    localparam int clkPeriod = 20;
    localparam int numRandom = 60;
    localparam int numIrqRounds = 20;
    // fixed tests stay under 300 cycles, an irq round takes at most 5
    localparam int stepBudget = numRandom + 5 * numIrqRounds + 300;
    localparam logic [xlen-1:0] mieMask = (32'h1 << irqSoft) | (32'h1 << irqTimer)
        | (32'h1 << irqExt);

    logic clk;
    logic rst;
    CsrReq req;
    TrapInfo trap;
    logic [commitWidth-1:0] commitCount;
    logic [counterWidth-1:0] mtime;
    logic [counterWidth-1:0] mtimecmp;
    logic softIrq;
    logic extIrq;
    CsrResp resp;
    TrapCtrl trapCtrl;

    // reference model state
    PrivLevel mPriv;
    PrivLevel mMpp;
    logic mMie;
    logic mMpie;
    logic [xlen-1:0] mMtvec;
    logic [xlen-1:0] mMscratch;
    logic [xlen-1:0] mMepc;
    logic [xlen-1:0] mMcause;
    logic [xlen-1:0] mMieReg;
    logic [xlen-2:0] mRetvec;
    logic inhCy, inhIr, enCy, enIr;
    logic [counterWidth-1:0] mCycle;
    logic [counterWidth-1:0] mInstret;
    logic tPend;
    CsrResp expQ[$];

    int errs;
    int checks;
    int testErrs;
    int testsRun;
    int testsFailed;

    csrUnit UUT (
        .clk(clk), .rst(rst), .req(req), .trap(trap), .commitCount(commitCount),
        .mtime(mtime), .mtimecmp(mtimecmp), .softIrq(softIrq), .extIrq(extIrq),
        .resp(resp), .trapCtrl(trapCtrl)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) mtime <= mtime + 64'd1;

    function automatic logic [xlen-1:0] mipNow();
        logic [xlen-1:0] v;
        v = '0;
        v[irqSoft] = softIrq;
        v[irqTimer] = tPend;
        v[irqExt] = extIrq;
        return v;
    endfunction

    function automatic logic [xlen-1:0] readModel(input logic [addrWidth-1:0] a,
                                                  output logic hit, output logic denied);
        logic [xlen-1:0] v;
        v = '0;
        hit = 1'b1;
        denied = 1'b0;
        case (a)
            addrMstatus: v = {19'b0, mMpp, 3'b0, mMpie, 3'b0, mMie, 3'b0};
            addrMisa: v = misaValue;
            addrMie: v = mMieReg;
            addrMtvec: v = mMtvec;
            addrMcounteren: v = {29'b0, enIr, 1'b0, enCy};
            addrMcountinhibit: v = {29'b0, inhIr, 1'b0, inhCy};
            addrMscratch: v = mMscratch;
            addrMepc: v = mMepc;
            addrMcause: v = mMcause;
            addrMip: v = mipNow();
            addrMcycle: v = mCycle[31:0];
            addrMcycleh: v = mCycle[63:32];
            addrMinstret: v = mInstret[31:0];
            addrMinstreth: v = mInstret[63:32];
            addrCycle, addrCycleh: begin
                v = a[7] ? mCycle[63:32] : mCycle[31:0];
                denied = (mPriv == privUser) && !enCy;
            end
            addrInstret, addrInstreth: begin
                v = a[7] ? mInstret[63:32] : mInstret[31:0];
                denied = (mPriv == privUser) && !enIr;
            end
            addrMhartid: v = '0;
            default: hit = 1'b0;
        endcase
        return v;
    endfunction

    function automatic CsrResp expectResp(input CsrReq r, output logic doWr,
                                          output logic [xlen-1:0] wv);
        CsrResp e;
        logic hit;
        logic denied;
        logic isWr;
        logic illegal;
        logic [xlen-1:0] old;
        old = readModel(r.addr, hit, denied);
        isWr = (r.op == opWrite) || (r.op == opSet) || (r.op == opClear);
        if (r.op == opMret)
            illegal = mPriv == privUser;
        else
            illegal = !hit || denied || (r.addr[9:8] > mPriv)
                || (isWr && r.addr[11:10] == 2'b11);
        case (r.op)
            opWrite: wv = r.operand;
            opSet: wv = old | r.operand;
            opClear: wv = old & ~r.operand;
            default: wv = old;
        endcase
        doWr = isWr && !illegal;
        e.valid = 1'b1;
        if (illegal) begin
            e.flag = flagIllegal;
            e.result = '0;
        end else if (r.op == opMret) begin
            e.flag = flagXret;
            e.result = '0;
        end else begin
            e.flag = flagNone;
            e.result = old;
        end
        return e;
    endfunction

    function automatic void expectIrq(output logic pend, output logic [3:0] cause);
        logic [xlen-1:0] act;
        act = mipNow() & mMieReg;
        pend = ((mPriv == privUser) || mMie) && (|act);
        cause = '0;
        if (pend) begin
            if (act[irqExt])
                cause = 4'(irqExt);
            else if (act[irqSoft])
                cause = 4'(irqSoft);
            else
                cause = 4'(irqTimer);
        end
    endfunction

    task automatic writeModel(input logic [addrWidth-1:0] a, input logic [xlen-1:0] v,
                              inout logic [counterWidth-1:0] cy,
                              inout logic [counterWidth-1:0] ir);
        case (a)
            addrMstatus: begin
                mMie = v[3];
                mMpie = v[7];
                mMpp = (v[12:11] == 2'b11) ? privMachine : privUser;
            end
            addrMie: mMieReg = v & mieMask;
            addrMtvec: mMtvec = v & ~32'h3;
            addrMcounteren: begin
                enCy = v[0];
                enIr = v[2];
            end
            addrMcountinhibit: begin
                inhCy = v[0];
                inhIr = v[2];
            end
            addrMscratch: mMscratch = v;
            addrMepc: mMepc = v & ~32'h1;
            addrMcause: mMcause = {v[31], 27'b0, v[3:0]};
            addrMcycle: cy = {mCycle[63:32], v};
            addrMcycleh: cy = {v, mCycle[31:0]};
            addrMinstret: ir = {mInstret[63:32], v};
            addrMinstreth: ir = {v, mInstret[31:0]};
            default: ; // misa, mip, hartid ignore writes
        endcase
    endtask

    // model steps on the same edges as the DUT
    always @(posedge clk) begin : model
        CsrResp want;
        logic doWr;
        logic [xlen-1:0] wv;
        logic [counterWidth-1:0] nextCy;
        logic [counterWidth-1:0] nextIr;
        if (rst) begin
            mPriv = privMachine;
            mMpp = privUser;
            mMie = 1'b0;
            mMpie = 1'b0;
            mMtvec = '0;
            mMscratch = '0;
            mMepc = '0;
            mMcause = '0;
            mMieReg = '0;
            mRetvec = '0;
            {inhCy, inhIr, enCy, enIr} = '0;
            mCycle = '0;
            mInstret = '0;
            tPend = 1'b0;
            expQ.delete();
        end else begin
            nextCy = inhCy ? mCycle : mCycle + 64'd1;
            nextIr = inhIr ? mInstret : mInstret + 64'(commitCount);
            if (trap.valid) begin
                mMepc = trap.pc & ~32'h1;
                mMcause = {trap.isInterrupt, 27'b0, trap.cause};
                mMpie = mMie;
                mMie = 1'b0;
                mMpp = mPriv;
                mPriv = privMachine;
            end else if (req.valid) begin
                want = expectResp(req, doWr, wv);
                expQ.push_back(want);
                if (want.flag == flagXret) begin
                    mMie = mMpie;
                    mPriv = mMpp;
                    mMpp = privUser;
                    mRetvec = mMepc[xlen-1:1];
                end else if (doWr) begin
                    writeModel(req.addr, wv, nextCy, nextIr);
                end
            end
            mCycle = nextCy;
            mInstret = nextIr;
            tPend = mtime >= mtimecmp; // seen one cycle late
        end
    end

    // compare mid-cycle, away from the edge
    always @(negedge clk) begin : compare
        CsrResp want;
        logic wantPend;
        logic [3:0] wantCause;
        if (!rst) begin
            if (resp.valid) begin
                if (expQ.size() == 0) begin
                    $display("Response at %0t ns with no request outstanding", $time);
                    errs++;
                end else begin
                    want = expQ.pop_front();
                    checks++;
                    if (resp.flag !== want.flag || resp.result !== want.result) begin
                        $display("** Error at %0t ns: resp flag %0d result %h, expected %0d %h",
                                 $time, resp.flag, resp.result, want.flag, want.result);
                        errs++;
                    end
                end
            end else if (expQ.size() != 0) begin
                $display("Response missing at %0t ns for an accepted request", $time);
                void'(expQ.pop_front());
                errs++;
            end
            expectIrq(wantPend, wantCause);
            checks++;
            if (trapCtrl.interruptPending !== wantPend
                    || trapCtrl.interruptCause !== wantCause) begin
                $display("** Error at %0t ns: irq pending %b cause %0d, expected %b %0d",
                         $time, trapCtrl.interruptPending, trapCtrl.interruptCause,
                         wantPend, wantCause);
                errs++;
            end
            if (trapCtrl.priv !== mPriv) begin
                $display("** Error at %0t ns: priv %0d, expected %0d", $time,
                         trapCtrl.priv, mPriv);
                errs++;
            end
            if (trapCtrl.retvec !== mRetvec || trapCtrl.mtvecBase !== mMtvec[xlen-1:2]) begin
                $display("** Error at %0t ns: retvec %h mtvecBase %h, expected %h %h", $time,
                         trapCtrl.retvec, trapCtrl.mtvecBase, mRetvec, mMtvec[xlen-1:2]);
                errs++;
            end
        end
    end

    task automatic issue(input CsrOp op, input logic [addrWidth-1:0] a,
                         input logic [xlen-1:0] v);
        @(posedge clk);
        req <= '{valid: 1'b1, op: op, addr: a, operand: v};
        commitCount <= commitWidth'($urandom_range(4, 0));
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            req.valid <= 1'b0;
            commitCount <= commitWidth'($urandom_range(4, 0));
        end
    endtask

    task automatic pulseTrap(input logic [3:0] cause, input logic isInt,
                             input logic [xlen-1:0] pc);
        @(posedge clk);
        req.valid <= 1'b0;
        trap <= '{valid: 1'b1, isInterrupt: isInt, cause: cause, pc: pc};
        @(posedge clk);
        trap.valid <= 1'b0;
    endtask

    task automatic finishTest(input string name);
        idle(2); // drain responses
        testsRun++;
        if (errs != testErrs)
            testsFailed++;
        $display("test %0d %s: %0d errors", testsRun, name, errs - testErrs);
        testErrs = errs;
    endtask

    initial begin
        #(stepBudget * clkPeriod + 2000);
        $display("Watchdog expired before the tests finished");
        $display(">>> FAIL");
        $finish;
    end

    initial begin : stimulus
        logic [addrWidth-1:0] a;
        void'($urandom(32'h7ed6));
        {errs, checks, testErrs, testsRun, testsFailed} = '0;
        rst = 1'b1;
        req = '0;
        trap = '0;
        commitCount = '0;
        mtime = '0;
        mtimecmp = '1;
        softIrq = 1'b0;
        extIrq = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        repeat (numRandom) begin
            case ($urandom_range(2, 0))
                0: a = addrMscratch;
                1: a = addrMepc;
                default: a = addrMie;
            endcase
            issue(CsrOp'($urandom_range(3, 0)), a, $urandom);
        end
        finishTest("random access");

        issue(opWrite, addrMcountinhibit, 32'h1);
        issue(opRead, addrMcycle, 32'h0);
        idle(3);
        issue(opRead, addrMcycle, 32'h0);
        issue(opWrite, addrMcountinhibit, 32'h0);
        repeat (4) begin
            issue(opRead, addrMcycle, 32'h0);
            idle($urandom_range(5, 0));
        end
        repeat (4) begin
            issue(opRead, addrMinstret, 32'h0);
            idle($urandom_range(5, 0));
        end
        issue(opWrite, addrMcycle, 32'hFFFF_FFF0); // carry into the high half
        repeat (12) begin
            issue(opRead, addrMcycle, 32'h0);
            issue(opRead, addrMcycleh, 32'h0);
        end
        issue(opWrite, addrMinstreth, $urandom);
        issue(opRead, addrMinstreth, 32'h0);
        issue(opRead, addrInstret, 32'h0);
        finishTest("counters");

        issue(opWrite, addrMtvec, $urandom);
        issue(opSet, addrMstatus, 32'h8); // mie set so mpie has something to save
        pulseTrap(4'd7, 1'b1, $urandom);
        issue(opRead, addrMepc, 32'h0);
        issue(opRead, addrMcause, 32'h0);
        issue(opRead, addrMstatus, 32'h0);
        issue(opClear, addrMstatus, 32'h1800); // mpp to user
        issue(opSet, addrMstatus, 32'h80);
        issue(opMret, 12'h000, 32'h0);
        finishTest("trap and mret");

        issue(opRead, addrMscratch, 32'h0);
        issue(opWrite, addrMscratch, $urandom);
        issue(opWrite, addrMstatus, 32'h8);
        issue(opMret, 12'h000, 32'h0);
        pulseTrap(4'd8, 1'b0, $urandom);
        issue(opRead, 12'h7C0, 32'h0);
        issue(opWrite, addrCycle, $urandom);
        issue(opWrite, addrMhartid, $urandom);
        issue(opWrite, addrMisa, $urandom);
        issue(opRead, addrMisa, 32'h0);
        issue(opRead, addrMscratch, 32'h0);
        issue(opRead, addrMcause, 32'h0);
        finishTest("illegal access");

        issue(opMret, 12'h000, 32'h0);
        issue(opRead, addrCycle, 32'h0);
        pulseTrap(4'd8, 1'b0, $urandom);
        issue(opSet, addrMcounteren, 32'h1);
        issue(opMret, 12'h000, 32'h0);
        issue(opRead, addrCycle, 32'h0);
        issue(opRead, addrCycleh, 32'h0);
        issue(opRead, addrInstret, 32'h0);
        pulseTrap(4'd8, 1'b0, $urandom);
        finishTest("user counters");

        issue(opWrite, addrMie, 32'hFFFF_FFFF);
        idle(1);
        softIrq <= 1'b1;
        idle(2);
        issue(opSet, addrMstatus, 32'h8);
        idle(1);
        mtimecmp <= '0;
        idle(3);
        softIrq <= 1'b0;
        idle(2);
        extIrq <= 1'b1;
        idle(2);
        issue(opClear, addrMie, 32'h800);
        idle(1);
        mtimecmp <= mtime + 64'd4;
        idle(8);
        mtimecmp <= '1;
        issue(opSet, addrMie, 32'h800);
        issue(opClear, addrMstatus, 32'h1808);
        issue(opMret, 12'h000, 32'h0); // user mode takes it regardless
        idle(2);
        extIrq <= 1'b0;
        pulseTrap(4'd11, 1'b1, $urandom);
        repeat (numIrqRounds) begin
            issue(opWrite, addrMie, $urandom);
            issue(opWrite, addrMstatus, $urandom & 32'h1888);
            @(posedge clk);
            req.valid <= 1'b0;
            softIrq <= 1'($urandom_range(1, 0));
            extIrq <= 1'($urandom_range(1, 0));
            case ($urandom_range(2, 0))
                0: mtimecmp <= '0;
                1: mtimecmp <= '1;
                default: mtimecmp <= mtime + 64'd2;
            endcase
            idle($urandom_range(2, 1));
        end
        finishTest("interrupts");

        if (expQ.size() != 0) begin
            $display("Requests were left without a response");
            errs++;
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checks, errs);
        if (errs == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
source/csrPkg.sv
source/csrCounters.sv
source/csrTrapState.sv
source/csrInterrupt.sv
source/csrAccess.sv
source/csrUnit.sv
tests/csrUnitTb.sv

/* Bender.yml */
package:
  name: csr_unit

sources:
  - source/csrPkg.sv
  - source/csrCounters.sv
  - source/csrTrapState.sv
  - source/csrInterrupt.sv
  - source/csrAccess.sv
  - source/csrUnit.sv
  - target: test
    files:
      - tests/csrUnitTb.sv
